/* Makefile */
.PHONY: all build run lint clean

all: run

build:
	verilator --binary --timing --assert -sv --top-module tb_ctrl_top -f ctrl_top.f \
		--Mdir obj_dir

run: build
	@out="$$(./obj_dir/Vtb_ctrl_top)"; echo "$$out"; \
		echo "$$out" | grep -q "Finished with no errors"

lint:
	verilator --lint-only -Wall -sv --top-module ctrl_top \
		common/ctrl_pkg.sv common/dec_if.sv decode/prefix_decode.sv \
		decode/exec_decode.sv design/imm_assembler.sv design/phase_seq.sv design/ctrl_top.sv

clean:
	rm -rf obj_dir

/* common/ctrl_pkg.sv */
// ======================================================================
// Control unit package
// Phase, ALU operation and opcode byte types, size codes, opcode
// constants and register code helpers
// ======================================================================
`default_nettype none

package ctrl_pkg;

    typedef enum logic [1:0] {
        FETCH    = 2'd0,
        EXEC     = 2'd1,
        FILL_IMM = 2'd2
    } phase_e;

    typedef enum logic [5:0] {
        ALU_NOP  = 6'd0,
        ALU_MOVE = 6'd1,
        ALU_ADD  = 6'd2,
        ALU_ADC  = 6'd3,
        ALU_SUB  = 6'd4,
        ALU_SBC  = 6'd5,
        ALU_AND  = 6'd6,
        ALU_OR   = 6'd7,
        ALU_XOR  = 6'd8,
        ALU_CP   = 6'd9,
        ALU_CPL  = 6'd10,
        ALU_CCF  = 6'd11
    } alu_op_e;

    typedef logic [1:0] size_t;     // zz field
    typedef logic [2:0] we_mask_t;  // one-hot byte/word/long

    // one opcode byte, seen as a register prefix or as a load-immediate
    typedef union packed {
        struct packed {
            logic [1:0] tag;
            size_t      zz;
            logic       flag;
            logic [2:0] rrr;
        } pre;
        struct packed {
            logic       zero_hi;
            logic [2:0] sz;
            logic       zero_lo;
            logic [2:0] rrr;
        } ldi;
    } op_byte_u;

    localparam size_t SZ_BYTE = 2'd0;
    localparam size_t SZ_WORD = 2'd1;
    localparam size_t SZ_LONG = 2'd2;
    localparam size_t SZ_JUMP = 2'd3;   // 24-bit address for JP

    localparam logic [3:0] REG_BANK_LO = 4'he;
    localparam logic [3:0] REG_BANK_HI = 4'hf;

    localparam logic [7:0] OP_NOP  = 8'h00;
    localparam logic [7:0] OP_CCF  = 8'h12;
    localparam logic [7:0] OP_LDF  = 8'h17;
    localparam logic [7:0] OP_INCF = 8'h0c;
    localparam logic [7:0] OP_DECF = 8'h0d;
    localparam logic [7:0] OP_JP16 = 8'h1a;
    localparam logic [7:0] OP_JP24 = 8'h1b;
    localparam logic [7:0] OP_LDRI = 8'h03;  // LD r,# after a prefix
    localparam logic [7:0] OP_CPL  = 8'h06;
    localparam logic [3:0] GRP_RI  = 4'hc;   // r,# arithmetic group

    function automatic we_mask_t size_mask(input size_t sz);
        case (sz)
            SZ_BYTE: return 3'b001;
            SZ_WORD: return 3'b010;
            default: return 3'b100;
        endcase
    endfunction

    function automatic logic [7:0] reg_code(input logic [2:0] r, input size_t sz);
        if (sz == SZ_BYTE)
            return {REG_BANK_LO, r[2:1], 1'b0, ~r[0]};  // byte halves swap order
        else if (r[2])
            return {REG_BANK_HI, r[1:0], 2'b00};
        else
            return {REG_BANK_LO, r[1:0], 2'b00};
    endfunction

endpackage

`default_nettype wire

/* common/dec_if.sv */
// ======================================================================
// Decoder proposal bundle
// One decoder's next control step, as read by the phase sequencer
// ======================================================================
`default_nettype none

interface dec_if;
    import ctrl_pkg::*;

    phase_e     next_phase;
    logic [1:0] fetched;
    logic [7:0] dst;
    logic [7:0] src;
    alu_op_e    alu_op;
    logic [7:0] imm_lo;
    logic       smux;
    we_mask_t   regs_we;
    we_mask_t   keep_we;    // write held back until the fill step
    logic       flag_we;
    logic       rfp_we;
    logic       inc_rfp;
    logic       dec_rfp;
    logic       jump;
    size_t      size;

    modport dec (output next_phase, fetched, dst, src, alu_op, imm_lo, smux, regs_we,
                 keep_we, flag_we, rfp_we, inc_rfp, dec_rfp, jump, size);
    modport seq (input  next_phase, fetched, dst, src, alu_op, imm_lo, smux, regs_we,
                 keep_we, flag_we, rfp_we, inc_rfp, dec_rfp, jump, size);
endinterface

`default_nettype wire

/* ctrl_top.f */
+incdir+tb
common/ctrl_pkg.sv
common/dec_if.sv
decode/prefix_decode.sv
decode/exec_decode.sv
design/imm_assembler.sv
design/phase_seq.sv
design/ctrl_top.sv
tb/tb_ctrl_top.sv

/* decode/exec_decode.sv */
// ======================================================================
// Second opcode byte decoder
// Decodes the byte after a register prefix as an operation group
// and a register: ALU R,r, ALU r,#, LD r,# and CPL
// ======================================================================
`default_nettype none

module exec_decode (
    input  wire [31:0]          op,
    input  wire ctrl_pkg::size_t size,
    input  wire [7:0]           prev_dst,
    dec_if.dec                  exe
);
    import ctrl_pkg::*;

    op_byte_u   b;
    logic [3:0] grp;
    alu_op_e    rr_op;
    alu_op_e    ri_op;
    logic       is_ri;
    logic       is_cp;

    assign b     = op[7:0];
    assign grp   = {b.pre.tag, b.pre.zz};
    assign is_ri = (grp == GRP_RI && b.pre.flag) || op[7:0] == OP_LDRI;
    assign is_cp = (grp == GRP_RI && b.pre.flag && b.pre.rrr == 3'd7);

    always_comb begin
        case (grp)  // R,r groups, 1ggg_0rrr
            4'h8:    rr_op = ALU_ADD;
            4'h9:    rr_op = ALU_ADC;
            4'ha:    rr_op = ALU_SUB;
            4'hc:    rr_op = ALU_AND;
            4'hd:    rr_op = ALU_XOR;
            4'he:    rr_op = ALU_OR;
            4'hf:    rr_op = ALU_CP;
            default: rr_op = ALU_NOP;
        endcase
        case (b.pre.rrr)  // 1100_1ooo
            3'd0:    ri_op = ALU_ADD;
            3'd1:    ri_op = ALU_ADC;
            3'd2:    ri_op = ALU_SUB;
            3'd3:    ri_op = ALU_SBC;
            3'd4:    ri_op = ALU_AND;
            3'd5:    ri_op = ALU_XOR;
            3'd6:    ri_op = ALU_OR;
            default: ri_op = ALU_CP;
        endcase
    end

    always_comb begin
        exe.next_phase = FETCH;
        exe.fetched    = 2'd1;
        exe.dst        = prev_dst;
        exe.src        = prev_dst;
        exe.alu_op     = ALU_NOP;
        exe.imm_lo     = 8'h00;
        exe.smux       = 1'b0;
        exe.regs_we    = '0;
        exe.keep_we    = '0;
        exe.flag_we    = 1'b0;
        exe.rfp_we     = 1'b0;
        exe.inc_rfp    = 1'b0;
        exe.dec_rfp    = 1'b0;
        exe.jump       = 1'b0;
        exe.size       = size;
        if (!b.pre.flag && rr_op != ALU_NOP) begin
            exe.dst    = reg_code(b.pre.rrr, size);  // R,r: prefix reg is the source
            exe.alu_op = rr_op;
            if (rr_op == ALU_CP)
                exe.flag_we = 1'b1;
            else
                exe.regs_we = size_mask(size);
        end else if (is_ri) begin
            exe.alu_op  = op[7:0] == OP_LDRI ? ALU_MOVE : ri_op;
            exe.smux    = 1'b1;
            exe.imm_lo  = op[15:8];
            exe.fetched = 2'd2;
            exe.flag_we = is_cp;
            if (size == SZ_BYTE) begin
                exe.regs_we = is_cp ? '0 : size_mask(size);
            end else begin
                exe.next_phase = FILL_IMM;   // rest of the immediate follows
                exe.keep_we    = is_cp ? '0 : size_mask(size);
            end
        end else if (op[7:0] == OP_CPL) begin
            exe.alu_op  = ALU_CPL;
            exe.regs_we = size_mask(size);
        end
    end

endmodule

`default_nettype wire

/* decode/prefix_decode.sv */
// ======================================================================
// First opcode byte decoder
// Proposes the step taken in the fetch phase: register prefix,
// load immediate, JP and the single-byte instructions
// ======================================================================
`default_nettype none

module prefix_decode (
    input  wire [31:0] op,
    dec_if.dec         pre
);
    import ctrl_pkg::*;

    op_byte_u b;
    size_t    ld_sz;

    assign b     = op[7:0];
    assign ld_sz = size_t'(b.ldi.sz - 3'd2);  // 2,3,4 -> byte,word,long

    always_comb begin
        pre.next_phase = FETCH;
        pre.fetched    = 2'd1;    // unknown bytes go as NOP
        pre.dst        = 8'h00;
        pre.src        = 8'h00;
        pre.alu_op     = ALU_NOP;
        pre.imm_lo     = 8'h00;
        pre.smux       = 1'b0;
        pre.regs_we    = '0;
        pre.keep_we    = '0;
        pre.flag_we    = 1'b0;
        pre.rfp_we     = 1'b0;
        pre.inc_rfp    = 1'b0;
        pre.dec_rfp    = 1'b0;
        pre.jump       = 1'b0;
        pre.size       = SZ_BYTE;
        if (b.pre.tag == 2'b11 && b.pre.flag && b.pre.zz != SZ_JUMP) begin
            pre.next_phase = EXEC;    // 11zz_1rrr
            pre.size       = b.pre.zz;
            pre.dst        = reg_code(b.pre.rrr, b.pre.zz);
            pre.src        = reg_code(b.pre.rrr, b.pre.zz);
        end else if (!b.ldi.zero_hi && !b.ldi.zero_lo && b.ldi.sz inside {3'd2, 3'd3, 3'd4})
        begin
            pre.fetched = 2'd2;       // LD R,#
            pre.size    = ld_sz;
            pre.dst     = reg_code(b.ldi.rrr, ld_sz);
            pre.src     = reg_code(b.ldi.rrr, ld_sz);
            pre.alu_op  = ALU_MOVE;
            pre.smux    = 1'b1;
            pre.imm_lo  = op[15:8];
            if (ld_sz == SZ_BYTE) begin
                pre.regs_we = size_mask(ld_sz);
            end else begin
                pre.next_phase = FILL_IMM;
                pre.keep_we    = size_mask(ld_sz);
            end
        end else begin
            case (op[7:0])
                OP_CCF: begin
                    pre.flag_we = 1'b1;
                    pre.alu_op  = ALU_CCF;
                end
                OP_LDF: begin
                    pre.rfp_we  = 1'b1;
                    pre.imm_lo  = op[15:8];
                    pre.fetched = 2'd2;
                end
                OP_INCF: pre.inc_rfp = 1'b1;
                OP_DECF: pre.dec_rfp = 1'b1;
                OP_JP16, OP_JP24: begin
                    pre.fetched    = 2'd2;
                    pre.imm_lo     = op[15:8];
                    pre.jump       = 1'b1;
                    pre.next_phase = FILL_IMM;
                    pre.size       = op[0] ? SZ_JUMP : SZ_WORD;
                end
                default: ;
            endcase
        end
    end

endmodule

`default_nettype wire

/* design/ctrl_top.sv */
// ======================================================================
// Instruction sequencing control unit
// Decodes the opcode window from the instruction queue and issues
// register file, ALU, RFP and PC control words
// ======================================================================
`default_nettype none

module ctrl_top (
    input  wire                     clk,
    input  wire                     rst,
    input  wire                     cen,
    input  wire [31:0]              op,       // byte 0 in op[7:0]
    input  wire                     op_ok,
    output logic [1:0]              fetched,
    output ctrl_pkg::we_mask_t      regs_we,
    output logic [7:0]              regs_dst,
    output logic [7:0]              regs_src,
    output ctrl_pkg::alu_op_e       alu_op,
    output logic [31:0]             alu_imm,
    output logic                    alu_smux,
    output logic                    alu_wait,
    output logic                    flag_we,
    output logic                    pc_we,
    output logic                    rfp_we,
    output logic                    inc_rfp,
    output logic                    dec_rfp
);
    import ctrl_pkg::*;

    size_t      size;
    logic [7:0] prev_dst;
    logic [7:0] imm_lo;
    logic       load_lo;
    logic       fill;

    dec_if i_pre_if ();
    dec_if i_exe_if ();

    prefix_decode i_prefix_decode (
        .op  (op),
        .pre (i_pre_if)
    );

    exec_decode i_exec_decode (
        .op       (op),
        .size     (size),
        .prev_dst (prev_dst),
        .exe      (i_exe_if)
    );

    phase_seq i_phase_seq (
        .clk      (clk),
        .rst      (rst),
        .cen      (cen),
        .op_ok    (op_ok),
        .pre      (i_pre_if),
        .exe      (i_exe_if),
        .fetched  (fetched),
        .load_lo  (load_lo),
        .fill     (fill),
        .imm_lo   (imm_lo),
        .size     (size),
        .prev_dst (prev_dst),
        .regs_we  (regs_we),
        .regs_dst (regs_dst),
        .regs_src (regs_src),
        .alu_op   (alu_op),
        .alu_smux (alu_smux),
        .alu_wait (alu_wait),
        .flag_we  (flag_we),
        .pc_we    (pc_we),
        .rfp_we   (rfp_we),
        .inc_rfp  (inc_rfp),
        .dec_rfp  (dec_rfp)
    );

    imm_assembler i_imm_assembler (
        .clk     (clk),
        .rst     (rst),
        .cen     (cen),
        .load_lo (load_lo),
        .fill    (fill),
        .imm_lo  (imm_lo),
        .size    (size),
        .op      (op),
        .imm     (alu_imm)
    );

endmodule

`default_nettype wire

/* design/imm_assembler.sv */
// ======================================================================
// Immediate assembler
// Takes the low byte from a decoder, then extends it with the
// following opcode bytes according to the operand size
// ======================================================================
`default_nettype none

module imm_assembler (
    input  wire                  clk,
    input  wire                  rst,
    input  wire                  cen,
    input  wire                  load_lo,
    input  wire                  fill,
    input  wire [7:0]            imm_lo,
    input  wire ctrl_pkg::size_t size,
    input  wire [31:0]           op,
    output logic [31:0]          imm
);
    import ctrl_pkg::*;

    always_ff @(posedge clk or posedge rst) begin
        if (rst) begin
            imm <= '0;
        end else if (cen) begin
            if (load_lo) begin
                imm <= {24'd0, imm_lo};
            end else if (fill) begin
                case (size)
                    SZ_WORD: imm[15:8] <= op[7:0];
                    SZ_LONG: imm[31:8] <= op[23:0];
                    SZ_JUMP: imm[23:8] <= op[15:0];   // top byte stays clear
                    default: ;
                endcase
            end
        end
    end

    // both strobes come from the sequencer's accept logic
    a_load_fill_excl: assert property (@(posedge clk) disable iff (rst)
        !(load_lo && fill));

endmodule

`default_nettype wire

/* design/phase_seq.sv */
// ======================================================================
// Phase sequencer
// Picks the decoder proposal for the current phase, runs the queue
// handshake and wait cycle, and registers the control outputs
// ======================================================================
`default_nettype none

module phase_seq (
    input  wire                     clk,
    input  wire                     rst,
    input  wire                     cen,
    input  wire                     op_ok,
    dec_if.seq                      pre,
    dec_if.seq                      exe,
    output logic [1:0]              fetched,
    output logic                    load_lo,
    output logic                    fill,
    output logic [7:0]              imm_lo,
    output ctrl_pkg::size_t         size,
    output logic [7:0]              prev_dst,
    output ctrl_pkg::we_mask_t      regs_we,
    output logic [7:0]              regs_dst,
    output logic [7:0]              regs_src,
    output ctrl_pkg::alu_op_e       alu_op,
    output logic                    alu_smux,
    output logic                    alu_wait,
    output logic                    flag_we,
    output logic                    pc_we,
    output logic                    rfp_we,
    output logic                    inc_rfp,
    output logic                    dec_rfp
);
    import ctrl_pkg::*;

    phase_e   phase;
    size_t    size_q;
    we_mask_t keep_we;
    logic     keep_flag;
    logic     jump_q;
    logic     wait_q;       // queue shifts during this cycle
    logic     accept;
    logic     in_fill;
    logic     use_exe;
    logic     defer;
    logic [1:0] fill_cnt;

    assign use_exe = phase == EXEC;
    assign in_fill = phase == FILL_IMM;
    assign accept  = cen && op_ok && !wait_q;
    assign load_lo = accept && !in_fill;
    assign fill    = accept && in_fill;
    assign defer   = (use_exe ? exe.next_phase : pre.next_phase) == FILL_IMM;
    assign imm_lo  = use_exe ? exe.imm_lo : pre.imm_lo;
    assign size    = size_q;
    assign prev_dst = regs_dst;

    always_comb begin
        case (size_q)
            SZ_LONG: fill_cnt = 2'd3;
            SZ_JUMP: fill_cnt = 2'd2;
            default: fill_cnt = 2'd1;
        endcase
        if (!accept)
            fetched = 2'd0;
        else if (in_fill)
            fetched = fill_cnt;
        else
            fetched = use_exe ? exe.fetched : pre.fetched;
    end

    always_ff @(posedge clk or posedge rst) begin
        if (rst) begin
            phase     <= FETCH;
            size_q    <= SZ_BYTE;
            keep_we   <= '0;
            keep_flag <= 1'b0;
            jump_q    <= 1'b0;
            wait_q    <= 1'b0;
            alu_op    <= ALU_NOP;
            alu_smux  <= 1'b0;
            alu_wait  <= 1'b0;
        end else if (cen) begin
            wait_q <= accept;
            if (fill) begin
                phase    <= FETCH;
                alu_wait <= 1'b0;
            end else if (load_lo) begin
                phase     <= use_exe ? exe.next_phase : pre.next_phase;
                size_q    <= use_exe ? exe.size : pre.size;
                keep_we   <= use_exe ? exe.keep_we : pre.keep_we;
                jump_q    <= use_exe ? exe.jump : pre.jump;
                keep_flag <= defer && (use_exe ? exe.flag_we : pre.flag_we);
                alu_op    <= use_exe ? exe.alu_op : pre.alu_op;
                alu_smux  <= use_exe ? exe.smux : pre.smux;
                alu_wait  <= defer;
            end
        end
    end

    // pulses last exactly one clock, even when cen drops
    always_ff @(posedge clk or posedge rst) begin
        if (rst) begin
            regs_we <= '0;
            flag_we <= 1'b0;
            pc_we   <= 1'b0;
            rfp_we  <= 1'b0;
            inc_rfp <= 1'b0;
            dec_rfp <= 1'b0;
        end else begin
            regs_we <= fill ? keep_we : load_lo ? (use_exe ? exe.regs_we : pre.regs_we) : '0;
            flag_we <= fill ? keep_flag :
                       load_lo && !defer && (use_exe ? exe.flag_we : pre.flag_we);
            pc_we   <= fill && jump_q;
            rfp_we  <= load_lo && (use_exe ? exe.rfp_we : pre.rfp_we);
            inc_rfp <= load_lo && (use_exe ? exe.inc_rfp : pre.inc_rfp);
            dec_rfp <= load_lo && (use_exe ? exe.dec_rfp : pre.dec_rfp);
        end
    end

    always_ff @(posedge clk) begin
        if (load_lo) begin
            regs_dst <= use_exe ? exe.dst : pre.dst;
            regs_src <= use_exe ? exe.src : pre.src;
        end
    end

    a_fetch_gap: assert property (@(posedge clk) disable iff (rst)
        accept |-> fetched != 2'd0 ##1 fetched == 2'd0);

    a_one_write: assert property (@(posedge clk) disable iff (rst)
        $onehot0({|regs_we, pc_we, rfp_we}));

    a_phase_legal: assert property (@(posedge clk) disable iff (rst)
        phase inside {FETCH, EXEC, FILL_IMM});

endmodule

`default_nettype wire

/* tb/ctrl_model.svh */
// ======================================================================
// Control unit testbench model
// LFSR source, instruction generator, opcode byte queue and
// expected control events and queue steps
// ======================================================================
`ifndef CTRL_MODEL_SVH
`define CTRL_MODEL_SVH

typedef struct packed {
    we_mask_t   regs_we;
    logic       flag_we;
    logic       pc_we;
    logic       rfp_we;
    logic       inc_rfp;
    logic       dec_rfp;
    logic       chk_reg;
    logic [7:0] dst;
    logic [7:0] src;
    alu_op_e    alu_op;
    logic       smux;
    logic [31:0] imm;
} exp_event_t;

logic [31:0] lfsr = 32'h8530_75ba;
logic [7:0]  byte_q[$];
exp_event_t  exp_q[$];
logic [2:0]  step_q[$];     // {alu_wait after, bytes taken}
alu_op_e     rr_tab[7] = '{ALU_ADD, ALU_ADC, ALU_SUB, ALU_AND, ALU_XOR, ALU_OR, ALU_CP};
logic [2:0]  rr_grp[7] = '{3'd0, 3'd1, 3'd2, 3'd4, 3'd5, 3'd6, 3'd7};
alu_op_e     ri_tab[8] = '{ALU_ADD, ALU_ADC, ALU_SUB, ALU_SBC,
                           ALU_AND, ALU_XOR, ALU_OR, ALU_CP};

function automatic logic [31:0] rand_bits(input int n);
    logic [31:0] v;
    v = '0;
    for (int i = 0; i < n; i++) begin
        v    = {v[30:0], lfsr[0]};
        lfsr = lfsr[0] ? (lfsr >> 1) ^ 32'h8020_0003 : lfsr >> 1;
    end
    return v;
endfunction

function automatic we_mask_t mask_of(input size_t sz);
    return we_mask_t'(3'b001 << sz);
endfunction

function automatic logic [7:0] reg_code_of(input logic [2:0] r, input size_t sz);
    if (sz == 2'd0)
        return {4'he, r[2], r[1], 1'b0, !r[0]};
    return {(r[2] ? 4'hf : 4'he), r[1], r[0], 2'b00};
endfunction

// pushes nb immediate bytes, low byte first, and returns their value
function automatic logic [31:0] push_imm(input logic [31:0] imm, input int nb);
    logic [31:0] val;
    val = '0;
    for (int i = 0; i < nb; i++) begin
        byte_q.push_back(imm[8*i +: 8]);
        val = val | (32'(imm[8*i +: 8]) << (8 * i));
    end
    return val;
endfunction

function automatic void queue_step(input logic [1:0] nbytes, input logic wt);
    step_q.push_back({wt, nbytes});
endfunction

// opcode step with the low immediate byte, then the fill step if any
function automatic void steps_for_imm(input int nb);
    queue_step(2'd2, nb > 1);
    if (nb > 1)
        queue_step(2'(nb - 1), 1'b0);
endfunction

task automatic gen_instr();
    exp_event_t  ev;
    logic [31:0] t;
    logic [31:0] imm;
    logic [2:0]  r1;
    logic [2:0]  r2;
    size_t       sz;
    int          k;
    int          nb;
    t   = rand_bits(4);
    k   = int'(t % 10);
    imm = rand_bits(32);
    t   = rand_bits(3);
    r1  = t[2:0];
    t   = rand_bits(3);
    r2  = t[2:0];
    t   = rand_bits(2);
    sz  = size_t'(t % 3);
    nb  = sz == 2'd0 ? 1 : sz == 2'd1 ? 2 : 4;   // immediate bytes
    ev  = '0;
    ev.alu_op = ALU_NOP;
    if (k < 4 || k > 6)
        queue_step(2'd1, 1'b0);     // single-byte op or register prefix
    case (k)
        0: byte_q.push_back(8'h00);
        1: begin
            byte_q.push_back(8'h12);
            ev.flag_we = 1'b1;
            ev.alu_op  = ALU_CCF;
        end
        2: begin
            byte_q.push_back(8'h0c);
            ev.inc_rfp = 1'b1;
        end
        3: begin
            byte_q.push_back(8'h0d);
            ev.dec_rfp = 1'b1;
        end
        4: begin
            byte_q.push_back(8'h17);
            ev.rfp_we = 1'b1;
            ev.imm    = push_imm(imm, 1);
            steps_for_imm(1);
        end
        5: begin
            byte_q.push_back({1'b0, 3'(sz) + 3'd2, 1'b0, r1});
            ev.imm     = push_imm(imm, nb);
            ev.regs_we = mask_of(sz);
            ev.chk_reg = 1'b1;
            ev.dst     = reg_code_of(r1, sz);
            ev.src     = ev.dst;
            ev.alu_op  = ALU_MOVE;
            ev.smux    = 1'b1;
            steps_for_imm(nb);
        end
        6: begin
            byte_q.push_back(r1[0] ? 8'h1b : 8'h1a);
            ev.imm   = push_imm(imm, r1[0] ? 3 : 2);
            ev.pc_we = 1'b1;
            steps_for_imm(r1[0] ? 3 : 2);
        end
        7: begin
            t = rand_bits(3);
            t = t % 7;
            byte_q.push_back({2'b11, sz, 1'b1, r1});
            byte_q.push_back({1'b1, rr_grp[t], 1'b0, r2});
            ev.alu_op  = rr_tab[t];
            ev.flag_we = ev.alu_op == ALU_CP;
            ev.regs_we = ev.alu_op == ALU_CP ? 3'b000 : mask_of(sz);
            ev.chk_reg = 1'b1;
            ev.dst     = reg_code_of(r2, sz);
            ev.src     = reg_code_of(r1, sz);
            queue_step(2'd1, 1'b0);
        end
        8: begin
            byte_q.push_back({2'b11, sz, 1'b1, r1});
            byte_q.push_back(r2 == 3'd0 ? 8'h03 : {5'b11001, imm[10:8]});
            ev.alu_op  = r2 == 3'd0 ? ALU_MOVE : ri_tab[imm[10:8]];
            ev.imm     = push_imm(imm, nb);
            ev.flag_we = ev.alu_op == ALU_CP;
            ev.regs_we = ev.alu_op == ALU_CP ? 3'b000 : mask_of(sz);
            ev.chk_reg = 1'b1;
            ev.dst     = reg_code_of(r1, sz);
            ev.src     = ev.dst;
            ev.smux    = 1'b1;
            steps_for_imm(nb);
        end
        default: begin
            byte_q.push_back({2'b11, sz, 1'b1, r1});
            byte_q.push_back(8'h06);
            ev.alu_op  = ALU_CPL;
            ev.regs_we = mask_of(sz);
            ev.chk_reg = 1'b1;
            ev.dst     = reg_code_of(r1, sz);
            ev.src     = ev.dst;
            queue_step(2'd1, 1'b0);
        end
    endcase
    if (k != 0)
        exp_q.push_back(ev);
endtask

`endif

/* tb/tb_ctrl_top.sv */
// ======================================================================
// Control unit testbench
// Random instruction stream through a stalling queue, checked
// against the expected control events
// ======================================================================
`default_nettype none

module tb_ctrl_top;
    import ctrl_pkg::*;

    localparam int N_INSTR    = 300;
    localparam int WATCHDOG_T = (16 + 20 * N_INSTR) * 20;

    logic        clk;
    logic        rst;
    logic        cen;
    logic [31:0] op;
    logic        op_ok;
    logic [1:0]  fetched;
    we_mask_t    regs_we;
    logic [7:0]  regs_dst;
    logic [7:0]  regs_src;
    alu_op_e     alu_op;
    logic [31:0] alu_imm;
    logic        alu_smux;
    logic        alu_wait;
    logic        flag_we;
    logic        pc_we;
    logic        rfp_we;
    logic        inc_rfp;
    logic        dec_rfp;
    logic        pulse;
    logic        last_acc;
    logic        exp_wait;      // alu_wait after the last step taken

    `include "ctrl_model.svh"

    ctrl_top i_dut (
        .clk(clk), .rst(rst), .cen(cen), .op(op), .op_ok(op_ok), .fetched(fetched),
        .regs_we(regs_we), .regs_dst(regs_dst), .regs_src(regs_src), .alu_op(alu_op),
        .alu_imm(alu_imm), .alu_smux(alu_smux), .alu_wait(alu_wait), .flag_we(flag_we),
        .pc_we(pc_we), .rfp_we(rfp_we), .inc_rfp(inc_rfp), .dec_rfp(dec_rfp)
    );

    assign pulse = |regs_we || flag_we || pc_we || rfp_we || inc_rfp || dec_rfp;

    task automatic fail_run(input string msg);
        $display("%s", msg);
        $display("Finished with errors");
        $fatal(1, "%s", msg);
    endtask

    task automatic cmp_mask(input string name, input we_mask_t got, input we_mask_t exp);
        if (got !== exp)
            fail_run($sformatf("mismatch %s got %h expected %h", name, got, exp));
    endtask

    task automatic cmp_op(input string name, input alu_op_e got, input alu_op_e exp);
        if (got !== exp)
            fail_run($sformatf("mismatch %s got %h expected %h", name, got, exp));
    endtask

    task automatic cmp_word(input string name, input logic [31:0] got, input logic [31:0] exp);
        if (got !== exp)
            fail_run($sformatf("mismatch %s got %h expected %h", name, got, exp));
    endtask

    task automatic cmp_byte(input string name, input logic [7:0] got, input logic [7:0] exp);
        if (got !== exp)
            fail_run($sformatf("mismatch %s got %h expected %h", name, got, exp));
    endtask

    task automatic cmp_count(input string name, input logic [1:0] got, input logic [1:0] exp);
        if (got !== exp)
            fail_run($sformatf("mismatch %s got %h expected %h", name, got, exp));
    endtask

    task automatic cmp_bit(input string name, input logic got, input logic exp);
        if (got !== exp)
            fail_run($sformatf("mismatch %s got %h expected %h", name, got, exp));
    endtask

    initial begin
        clk = 1'b0;
        forever #10 clk = ~clk;
    end

    initial begin
        #(WATCHDOG_T);
        fail_run("timeout, the instruction stream did not drain");
    end

    // queue side, popping what was consumed at this edge
    always @(posedge clk) begin
        logic [31:0] t;
        logic [2:0]  step;
        if (rst) begin
            last_acc = 1'b0;
            exp_wait = 1'b0;
        end else begin
            if (last_acc && fetched != 2'd0)
                fail_run("fetched nonzero in the wait cycle");
            last_acc = fetched != 2'd0;
            if (last_acc) begin
                if (step_q.size() == 0)
                    fail_run("DUT took a step past the end of the stream");
                step = step_q.pop_front();
                cmp_count("fetched", fetched, step[1:0]);
                exp_wait = step[2];
            end
            for (int i = 0; i < int'(fetched); i++)
                void'(byte_q.pop_front());
            t = rand_bits(2);
            op_ok <= byte_q.size() != 0 && t[1:0] != 2'd0;
            t = rand_bits(3);
            cen <= t[2:0] != 3'd0;
            for (int i = 0; i < 4; i++)
                op[8*i +: 8] <= i < byte_q.size() ? byte_q[i] : 8'h00;  // NOP padding
        end
    end

    always @(negedge clk) begin
        exp_event_t ev;
        if (rst) begin
            cmp_bit("pulse", pulse, 1'b0);
            cmp_bit("alu_wait", alu_wait, 1'b0);
            cmp_bit("alu_smux", alu_smux, 1'b0);
            cmp_op("alu_op", alu_op, ALU_NOP);
        end else begin
            cmp_bit("alu_wait", alu_wait, exp_wait);
            if (pulse) begin
                if (!last_acc)
                    fail_run("control pulse without an accepted step");
                if (exp_q.size() == 0)
                    fail_run("control pulse with no expected event left");
                ev = exp_q.pop_front();
                cmp_mask("regs_we", regs_we, ev.regs_we);
                cmp_bit("flag_we", flag_we, ev.flag_we);
                cmp_bit("pc_we", pc_we, ev.pc_we);
                cmp_bit("rfp_we", rfp_we, ev.rfp_we);
                cmp_bit("inc_rfp", inc_rfp, ev.inc_rfp);
                cmp_bit("dec_rfp", dec_rfp, ev.dec_rfp);
                cmp_op("alu_op", alu_op, ev.alu_op);
                cmp_bit("alu_smux", alu_smux, ev.smux);
                cmp_word("alu_imm", alu_imm, ev.imm);
                if (ev.chk_reg) begin
                    cmp_byte("regs_dst", regs_dst, ev.dst);
                    cmp_byte("regs_src", regs_src, ev.src);
                end
            end
        end
    end

    initial begin
        rst      = 1'b1;
        cen      = 1'b0;
        op_ok    = 1'b0;
        op       = '0;
        last_acc = 1'b0;
        exp_wait = 1'b0;
        for (int i = 0; i < N_INSTR; i++)
            gen_instr();
        repeat (16) @(posedge clk);
        rst <= 1'b0;
        while (step_q.size() != 0)
            @(posedge clk);
        repeat (4) @(posedge clk);
        if (exp_q.size() != 0)
            fail_run("expected control events never appeared");
        else
            $display("Finished with no errors");
        $finish;
    end

endmodule

`default_nettype wire
